// File: source/gfx_pkg.sv
package gfx_pkg;

	localparam int WORD_BITS = 32;          // One instruction, one memory word
	localparam int LANE_WORDS = 4;          // Instructions per lane
	localparam int INSN_BITS_IN_LANE = 2;   // Word select within a lane

	// Single word on the video memory bus
	typedef logic [WORD_BITS - 1:0] vram_word;

	// Word address on the memory bus
	typedef logic [23:0] vram_addr;

	// Instruction address, one instruction per word
	typedef logic [23:0] vram_insn_addr;

	// Word address without the word select bits
	typedef logic [23 - INSN_BITS_IN_LANE:0] vram_lane_addr;

	// Word i of a lane sits at bits 32i upward
	typedef logic [LANE_WORDS * WORD_BITS - 1:0] lane_word;

	// One valid bit per word of a lane
	typedef logic [LANE_WORDS - 1:0] lane_mask;

	// Batch length in instructions
	typedef logic [15:0] cmd_word;

endpackage

// File: source/gfx_lane_if.sv
interface gfx_lane_if
	import gfx_pkg::*;
	#(parameter int WIDTH = 22);

	logic               lane_read;
	logic [WIDTH - 1:0] lane_address;
	lane_word           lane_readdata;
	logic               lane_waitrequest;
	logic               lane_readdatavalid;

	// Sequencer side
	modport master (
		output lane_read,
		output lane_address,
		input  lane_readdata,
		input  lane_waitrequest,
		input  lane_readdatavalid
	);

	// Widener side
	modport slave (
		input  lane_read,
		input  lane_address,
		output lane_readdata,
		output lane_waitrequest,
		output lane_readdatavalid
	);

endinterface

// File: source/gfx_sp_widener.sv
module gfx_sp_widener
	import gfx_pkg::*;
#(
	parameter int WIDTH = 22
)
(
	input  logic      clk,
	input  logic      rst_n,

	gfx_lane_if.slave lane,

	output logic      word_read,
	output vram_addr  word_address,
	input  vram_word  word_readdata,
	input  logic      word_waitrequest,
	input  logic      word_readdatavalid
);

	localparam logic [INSN_BITS_IN_LANE - 1:0] LAST_WORD = INSN_BITS_IN_LANE'(LANE_WORDS - 1);

	logic [WIDTH - 1:0]             issue_lane;
	logic [INSN_BITS_IN_LANE - 1:0] issue_idx;
	logic [INSN_BITS_IN_LANE - 1:0] ret_idx;
	logic                           issue_busy;
	logic                           lane_done;
	logic                           lane_accept;
	lane_word                       assembly;

	// A new lane is taken only once the previous one has issued all its words
	assign lane.lane_waitrequest = issue_busy;
	assign lane.lane_readdata = assembly;
	assign lane.lane_readdatavalid = lane_done;

	assign lane_accept = lane.lane_read && !issue_busy;

	assign word_read = issue_busy;
	assign word_address = {issue_lane, issue_idx};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			issue_busy <= 1'b0;
			issue_idx <= '0;
			ret_idx <= '0;
			lane_done <= 1'b0;
		end else begin
			lane_done <= word_readdatavalid && ret_idx == LAST_WORD; // Lane complete

			if (word_readdatavalid)
				ret_idx <= ret_idx + 1'b1;

			if (lane_accept) begin
				issue_busy <= 1'b1;
				issue_idx <= '0;
			end else if (issue_busy && !word_waitrequest) begin
				issue_idx <= issue_idx + 1'b1;
				if (issue_idx == LAST_WORD)
					issue_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (lane_accept)
			issue_lane <= lane.lane_address;

		// Shift in from the top so the first word lands at the bottom
		if (word_readdatavalid)
			assembly <= {word_readdata, assembly[$bits(lane_word) - 1:WORD_BITS]};
	end

endmodule

// File: source/gfx_fifo.sv
module gfx_fifo
#(
	parameter int WIDTH = 8,
	parameter int FIFO_DEPTH = 8
)
(
	input  logic               clk,
	input  logic               rst_n,

	input  logic [WIDTH - 1:0] in,
	input  logic               in_valid,
	output logic               in_ready,

	output logic [WIDTH - 1:0] out,
	output logic               out_valid,
	input  logic               out_ready
);

	localparam int PTR_BITS = FIFO_DEPTH > 1 ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

	logic [WIDTH - 1:0]    mem [FIFO_DEPTH];
	logic [PTR_BITS - 1:0] rd_ptr;
	logic [PTR_BITS - 1:0] wr_ptr;
	logic [CNT_BITS - 1:0] count;
	logic                  buf_empty;
	logic                  load_out;
	logic                  buf_read;
	logic                  buf_write;

	function automatic logic [PTR_BITS - 1:0] ptr_inc(input logic [PTR_BITS - 1:0] ptr);
		return ptr == PTR_BITS'(FIFO_DEPTH - 1) ? '0 : ptr + 1'b1;
	endfunction

	assign buf_empty = count == '0;
	assign load_out = !out_valid || out_ready;  // Output register free next cycle
	assign buf_read = load_out && !buf_empty;
	assign buf_write = in_valid && in_ready && !(load_out && buf_empty); // Else bypass
	assign in_ready = count < CNT_BITS'(FIFO_DEPTH);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
			out_valid <= 1'b0;
		end else begin
			if (buf_read)
				rd_ptr <= ptr_inc(rd_ptr);
			if (buf_write)
				wr_ptr <= ptr_inc(wr_ptr);

			count <= count + CNT_BITS'(buf_write) - CNT_BITS'(buf_read);

			if (load_out)
				out_valid <= !buf_empty || in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (buf_write)
			mem[wr_ptr] <= in;

		if (buf_read)
			out <= mem[rd_ptr];
		else if (load_out && in_valid)
			out <= in;
	end

endmodule

// File: source/gfx_fifo_overflow.sv
module gfx_fifo_overflow
#(
	parameter int FIFO_DEPTH = 8
)
(
	input  logic clk,
	input  logic rst_n,

	input  logic down,      // Lane read accepted
	input  logic up,        // Lane popped from the FIFO
	output logic empty,
	output logic down_safe
);

	localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

	logic [CNT_BITS - 1:0] count;   // Lanes requested and not yet popped

	assign empty = count == '0;

	// A pop this cycle is not counted, so the credit stays conservative
	assign down_safe = down ? count < CNT_BITS'(FIFO_DEPTH - 1)
	                        : count < CNT_BITS'(FIFO_DEPTH);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			count <= '0;
		else
			count <= count + CNT_BITS'(down) - CNT_BITS'(up);
	end

endmodule

// File: source/gfx_sp_batch.sv
module gfx_sp_batch
	import gfx_pkg::*;
#(
	parameter int FIFO_DEPTH = 8
)
(
	input  logic          clk,
	input  logic          rst_n,

	input  logic          batch_waitrequest,
	input  logic          batch_readdatavalid,
	input  vram_word      batch_readdata,
	output vram_addr      batch_address,
	output logic          batch_read,

	input  logic          cmd_valid,
	output logic          cmd_ready,
	input  vram_insn_addr cmd_base,
	input  cmd_word       cmd_length,

	output lane_word      out_data,
	output lane_mask      out_mask,
	output logic          out_valid,
	input  logic          out_ready
);

	localparam int TAIL_BITS = INSN_BITS_IN_LANE;
	localparam int BLOCK_BITS = $bits(cmd_word) - TAIL_BITS;
	localparam int FIFO_BITS = $bits(lane_word) + $bits(lane_mask);
	localparam logic IDLE = 1'b0;
	localparam logic STREAM = 1'b1;

	logic                    state;
	logic                    cmd_accept;
	logic                    lane_read;
	logic                    lane_accept;
	logic                    down_safe;
	vram_lane_addr           lane_address;
	logic [BLOCK_BITS - 1:0] cmd_block;
	logic [TAIL_BITS - 1:0]  cmd_tail;
	logic [BLOCK_BITS - 1:0] fetch_block;
	logic [BLOCK_BITS - 1:0] ret_block;
	logic [TAIL_BITS - 1:0]  ret_tail;
	logic [BLOCK_BITS - 1:0] pend_block;
	logic [TAIL_BITS - 1:0]  pend_tail;
	logic                    ret_active;
	logic                    ret_last;
	logic                    pend_valid;
	lane_mask                ret_mask;
	logic [FIFO_BITS - 1:0]  fifo_in;
	logic [FIFO_BITS - 1:0]  fifo_out;

	gfx_lane_if #(.WIDTH($bits(vram_lane_addr))) lane ();

	gfx_sp_widener #(.WIDTH($bits(vram_lane_addr))) widener (
		.clk                (clk),
		.rst_n              (rst_n),
		.lane               (lane.slave),
		.word_read          (batch_read),
		.word_address       (batch_address),
		.word_readdata      (batch_readdata),
		.word_waitrequest   (batch_waitrequest),
		.word_readdatavalid (batch_readdatavalid)
	);

	gfx_fifo #(.WIDTH(FIFO_BITS), .FIFO_DEPTH(FIFO_DEPTH)) lane_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.in        (fifo_in),
		.in_valid  (lane.lane_readdatavalid),
		.in_ready  (),
		.out       (fifo_out),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

	gfx_fifo_overflow #(.FIFO_DEPTH(FIFO_DEPTH)) overflow (
		.clk       (clk),
		.rst_n     (rst_n),
		.down      (lane_accept),
		.up        (out_valid && out_ready),
		.empty     (),
		.down_safe (down_safe)
	);

	assign lane.lane_read = lane_read;
	assign lane.lane_address = lane_address;

	assign {cmd_block, cmd_tail} = cmd_length;
	assign {out_data, out_mask} = fifo_out;

	// A second batch may wait behind the one still returning, but no more
	assign cmd_ready = state == IDLE && !pend_valid;
	assign cmd_accept = cmd_valid && cmd_ready;
	assign lane_accept = lane_read && !lane.lane_waitrequest;

	assign ret_last = lane.lane_readdatavalid && ret_block == '0;
	assign ret_mask = ret_block == '0 ? lane_mask'((4'd1 << ret_tail) - 4'd1) : '1;
	assign fifo_in = {lane.lane_readdata, ret_mask};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			lane_read <= 1'b0;
			ret_active <= 1'b0;
			pend_valid <= 1'b0;
		end else begin
			unique case (state)
				IDLE:
					if (cmd_accept) begin
						state <= STREAM;
						lane_read <= down_safe;
					end

				STREAM: begin
					if (!lane_read || !lane.lane_waitrequest)
						lane_read <= down_safe; // Hold a pending read, else ask credit

					if (lane_accept && fetch_block == '0) begin
						state <= IDLE;
						lane_read <= 1'b0;
					end
				end
			endcase

			if (cmd_accept && ret_active && !ret_last)
				pend_valid <= 1'b1;
			else if (cmd_accept)
				ret_active <= 1'b1;
			else if (ret_last) begin
				ret_active <= pend_valid;
				pend_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_accept) begin
			fetch_block <= cmd_block;
			lane_address <= cmd_base[INSN_BITS_IN_LANE +: $bits(vram_lane_addr)];
		end else if (lane_accept) begin
			fetch_block <= fetch_block - 1'b1;
			lane_address <= lane_address + 1'b1;
		end

		if (cmd_accept && ret_active && !ret_last) begin
			pend_block <= cmd_block;
			pend_tail <= cmd_tail;
		end

		if (cmd_accept && !(ret_active && !ret_last)) begin
			ret_block <= cmd_block;
			ret_tail <= cmd_tail;
		end else if (ret_last) begin
			ret_block <= pend_block;    // Next batch's return side
			ret_tail <= pend_tail;
		end else if (lane.lane_readdatavalid)
			ret_block <= ret_block - 1'b1;
	end

endmodule

// File: source/gfx_sp_front.sv
module gfx_sp_front
	import gfx_pkg::*;
#(
	parameter int FIFO_DEPTH = 8
)
(
	input  logic          clk,
	input  logic          rst_n,

	output logic          batch_read,
	output vram_addr      batch_address,
	input  vram_word      batch_readdata,
	input  logic          batch_waitrequest,
	input  logic          batch_readdatavalid,

	input  logic          cmd_valid,
	output logic          cmd_ready,
	input  vram_insn_addr cmd_base,
	input  cmd_word       cmd_length,

	output lane_word      out_data,
	output lane_mask      out_mask,
	output logic          out_valid,
	input  logic          out_ready
);

	gfx_sp_batch #(.FIFO_DEPTH(FIFO_DEPTH)) batch (
		.clk                 (clk),
		.rst_n               (rst_n),
		.batch_waitrequest   (batch_waitrequest),
		.batch_readdatavalid (batch_readdatavalid),
		.batch_readdata      (batch_readdata),
		.batch_address       (batch_address),
		.batch_read          (batch_read),
		.cmd_valid           (cmd_valid),
		.cmd_ready           (cmd_ready),
		.cmd_base            (cmd_base),
		.cmd_length          (cmd_length),
		.out_data            (out_data),
		.out_mask            (out_mask),
		.out_valid           (out_valid),
		.out_ready           (out_ready)
	);

endmodule

// File: tests/tb_clock.sv
module tb_clock
#(
	parameter real PERIOD = 8.0
)
(
	output logic clk
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever
			#(PERIOD / 2.0) clk = ~clk;
	end

endmodule

// File: tests/vram_model.sv
module vram_model
	import gfx_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,

	input  logic          batch_read,
	input  vram_addr      batch_address,
	output vram_word      batch_readdata,
	output logic          batch_waitrequest,
	output logic          batch_readdatavalid,

	input  logic          cmd_valid,
	input  logic          cmd_ready,
	input  vram_insn_addr cmd_base,
	input  cmd_word       cmd_length,

	output logic          addr_error
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WAIT_PCT = 30;   // Chance of waitrequest per cycle

	integer   seed = 32'hd5ca;
	vram_addr start_q[$];           // Aligned base of each accepted batch
	int       words_q[$];
	vram_addr next_addr;
	int       words_left;
	logic     accepted;
	logic     d1_valid;
	logic     d2_valid;
	vram_addr d1_addr;
	vram_addr d2_addr;

	function automatic vram_word word_at(input vram_addr a);
		return 32'(a) * 32'h9E3779B1;
	endfunction

	task automatic check_address(input vram_addr addr);
		assert (words_left != 0 || start_q.size() != 0) else begin
			$display("Memory read at address %h arrived with no batch pending", addr);
			addr_error = 1'b1;
		end
		if (words_left == 0 && start_q.size() != 0) begin
			next_addr = start_q.pop_front();
			words_left = words_q.pop_front();
		end
		assert (addr == next_addr) else begin
			$display("Mismatch batch_address: expected %h, got %h", next_addr, addr);
			addr_error = 1'b1;
		end
		next_addr = addr + 24'd1;
		words_left = words_left - 1;
	endtask

	initial begin
		batch_readdata = '0;
		batch_waitrequest = 1'b0;
		batch_readdatavalid = 1'b0;
		addr_error = 1'b0;
		next_addr = '0;
		words_left = 0;
		d1_valid = 1'b0;
		d2_valid = 1'b0;
		d1_addr = '0;
		d2_addr = '0;
		forever begin
			@(posedge clk);
			accepted = rst_n && batch_read && !batch_waitrequest;
			if (rst_n && cmd_valid && cmd_ready) begin
				start_q.push_back({cmd_base[23:2], 2'b00});
				words_q.push_back((int'(cmd_length) / 4 + 1) * 4);
			end
			if (accepted)
				check_address(batch_address);
			d2_valid = d1_valid;        // Two-cycle read pipeline
			d2_addr = d1_addr;
			d1_valid = accepted;
			d1_addr = batch_address;
			#1;
			batch_readdatavalid = d2_valid;
			batch_readdata = d2_valid ? word_at(d2_addr) : '0;
			batch_waitrequest = rst_n && ({$random(seed)} % 100 < WAIT_PCT);
		end
	end

endmodule

// File: tests/gfx_sp_front_tb.sv
module gfx_sp_front_tb
	import gfx_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WATCH_LANE_CYCLES = 40;
	localparam int WATCH_EXTRA_CYCLES = 200;

	logic          clk;
	logic          rst_n;
	logic          batch_read;
	vram_addr      batch_address;
	vram_word      batch_readdata;
	logic          batch_waitrequest;
	logic          batch_readdatavalid;
	logic          cmd_valid;
	logic          cmd_ready;
	vram_insn_addr cmd_base;
	cmd_word       cmd_length;
	lane_word      out_data;
	lane_mask      out_mask;
	logic          out_valid;
	logic          out_ready;
	logic          addr_error;

	integer        seed = 32'hd5ca;
	int            ready_pct = 100;
	int            watch_cycles = 0;    // Set once the command file is read
	vram_insn_addr base_list[$];
	cmd_word       length_list[$];
	int            pct_list[$];
	logic          b2b_list[$];
	lane_word      exp_data[$];
	lane_mask      exp_mask[$];

	tb_clock #(.PERIOD(8.0)) clock_gen (.clk(clk));

	gfx_sp_front #(.FIFO_DEPTH(8)) UUT (
		.clk                 (clk),
		.rst_n               (rst_n),
		.batch_read          (batch_read),
		.batch_address       (batch_address),
		.batch_readdata      (batch_readdata),
		.batch_waitrequest   (batch_waitrequest),
		.batch_readdatavalid (batch_readdatavalid),
		.cmd_valid           (cmd_valid),
		.cmd_ready           (cmd_ready),
		.cmd_base            (cmd_base),
		.cmd_length          (cmd_length),
		.out_data            (out_data),
		.out_mask            (out_mask),
		.out_valid           (out_valid),
		.out_ready           (out_ready)
	);

	vram_model vram (
		.clk                 (clk),
		.rst_n               (rst_n),
		.batch_read          (batch_read),
		.batch_address       (batch_address),
		.batch_readdata      (batch_readdata),
		.batch_waitrequest   (batch_waitrequest),
		.batch_readdatavalid (batch_readdatavalid),
		.cmd_valid           (cmd_valid),
		.cmd_ready           (cmd_ready),
		.cmd_base            (cmd_base),
		.cmd_length          (cmd_length),
		.addr_error          (addr_error)
	);

	task automatic stop_with_failure(input string reason);
		$display("ERRORS FOUND");
		$fatal(1, "%s", reason);
	endtask

	task automatic expect_bit(input string name, input logic got, input logic want);
		assert (got === want) else begin
			$display("Mismatch %s: expected %h, got %h", name, want, got);
			stop_with_failure({name, " has the wrong value"});
		end
	endtask

	function automatic vram_word mem_word(input vram_addr a);
		return 32'(a) * 32'h9E3779B1;
	endfunction

	// Lanes start at the aligned base and only the last one is partial
	task automatic push_expected(input vram_insn_addr base, input cmd_word length);
		int       lanes;
		vram_addr addr;
		lane_word data;
		lane_mask mask;
		lanes = int'(length) / 4 + 1;
		for (int i = 0; i < lanes; i++) begin
			for (int j = 0; j < 4; j++) begin
				addr = {base[23:2], 2'b00} + vram_addr'(4 * i + j);
				data[32 * j +: 32] = mem_word(addr);
			end
			if (i < lanes - 1)
				mask = 4'hf;
			else
				mask = 4'hf >> (4 - int'(length[1:0]));
			exp_data.push_back(data);
			exp_mask.push_back(mask);
		end
	endtask

	task automatic issue_command(input vram_insn_addr base, input cmd_word length);
		cmd_valid = 1'b1;
		cmd_base = base;
		cmd_length = length;
		@(posedge clk);
		while (!cmd_ready)
			@(posedge clk);
		push_expected(base, length);
		#1;
		cmd_valid = 1'b0;
		expect_bit("cmd_ready", cmd_ready, 1'b0);   // Busy right after accept
	endtask

	task automatic wait_drained();
		while (exp_data.size() != 0) begin
			@(posedge clk);
			#1;
		end
	endtask

	initial begin
		int            fd;
		string         line;
		vram_insn_addr base;
		int            length;
		int            pct;
		int            b2b;
		int            total_lanes;

		rst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd_base = '0;
		cmd_length = '0;
		total_lanes = 0;

		fd = $fopen("tests/batch_input.txt", "r");
		assert (fd != 0) else
			stop_with_failure("could not open tests/batch_input.txt");
		while (!$feof(fd)) begin
			if ($fgets(line, fd) != 0 &&
				$sscanf(line, "%h %d %d %d", base, length, pct, b2b) == 4) begin
				base_list.push_back(base);
				length_list.push_back(cmd_word'(length));
				pct_list.push_back(pct);
				b2b_list.push_back(b2b != 0);
				total_lanes += length / 4 + 1;
			end
		end
		$fclose(fd);
		watch_cycles = total_lanes * WATCH_LANE_CYCLES + WATCH_EXTRA_CYCLES;

		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge clk);
		expect_bit("cmd_ready", cmd_ready, 1'b1);
		expect_bit("out_valid", out_valid, 1'b0);
		expect_bit("batch_read", batch_read, 1'b0);
		#1;

		for (int n = 0; n < base_list.size(); n++) begin
			if (!b2b_list[n])
				wait_drained();
			ready_pct = pct_list[n];
			issue_command(base_list[n], length_list[n]);
		end
		wait_drained();

		repeat (4) @(posedge clk);
		expect_bit("cmd_ready", cmd_ready, 1'b1);
		expect_bit("out_valid", out_valid, 1'b0);
		expect_bit("batch_read", batch_read, 1'b0);
		$display("NO ERRORS");
		$finish;
	end

	// Random stalls on the output side
	initial begin
		out_ready = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			out_ready = rst_n && ({$random(seed)} % 100 < ready_pct);
		end
	end

	always @(posedge clk) begin
		lane_word want_data;
		lane_mask want_mask;
		if (rst_n && out_valid && out_ready) begin
			assert (exp_data.size() != 0) else
				stop_with_failure("a lane came out while no lane was expected");
			if (exp_data.size() != 0) begin
				want_data = exp_data.pop_front();
				want_mask = exp_mask.pop_front();
				assert (out_data === want_data) else begin
					$display("Mismatch out_data: expected %h, got %h", want_data, out_data);
					stop_with_failure("out_data mismatch");
				end
				assert (out_mask === want_mask) else begin
					$display("Mismatch out_mask: expected %h, got %h", want_mask, out_mask);
					stop_with_failure("out_mask mismatch");
				end
			end
		end
	end

	always @(addr_error)
		assert (!addr_error) else
			stop_with_failure("the memory model saw a wrong word address");

	initial begin
		wait (watch_cycles != 0);
		repeat (watch_cycles) @(posedge clk);
		$display("Timeout after %0d cycles, %0d lanes never came out", watch_cycles,
			exp_data.size());
		stop_with_failure("watchdog timeout");
	end

endmodule

// File: gfx_sp_front.f
source/gfx_pkg.sv
source/gfx_lane_if.sv
source/gfx_sp_widener.sv
source/gfx_fifo.sv
source/gfx_fifo_overflow.sv
source/gfx_sp_batch.sv
source/gfx_sp_front.sv
tests/tb_clock.sv
tests/vram_model.sv
tests/gfx_sp_front_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root

set -u
cd "$(dirname "$0")" || exit 1

top=gfx_sp_front_tb
build_dir=obj_dir

verilator --binary --timing --timescale 1ns/1ps \
	--top-module "$top" \
	--Mdir "$build_dir" \
	-o "$top" \
	-f gfx_sp_front.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

"./$build_dir/$top"
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi

echo "Simulation passed"
exit 0

// File: tests/batch_input.txt
# base(hex) length(dec) out_ready_percent back_to_back
# back_to_back 1 presents the command at once, 0 waits until all earlier lanes are out
000100 5 100 0
000203 6 100 0
000010 0 100 0
000021 1 100 0
000032 2 100 0
000043 3 100 0
000054 4 100 0
000400 8 100 0
001002 13 60 0
00fff1 37 30 0
0a0000 60 20 0
123457 44 50 1
123800 7 50 1
000600 16 100 1
ffffe5 20 70 0
3fff02 23 70 1
000700 12 40 0
000803 9 25 1
